/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;

  localparam int NUM_REGS = 32;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP_LOAD    = 7'b0000011,
    OP_STORE   = 7'b0100011,
    OP_BRANCH  = 7'b1100011,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_SYSTEM  = 7'b1110011,
    OP_LUI     = 7'b0110111,
    OP_JAL     = 7'b1101111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_t;

  // Branch conditions, encoded as their funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_t;

  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // addi x0, x0, 0
  localparam xlen_t INSN_NOP = 32'h0000_0013;

  typedef struct packed {
    xlen_t    pc;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     is_jal;
    logic     is_ecall;
    logic     we;
    br_cond_t br_cond;
  } decoded_insn_t;

endpackage

`default_nettype wire

/* hdl/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

  // Memory depths in 32-bit words
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;

  // Word index widths
  localparam int IMEM_AW = 8;
  localparam int DMEM_AW = 8;

  typedef logic [IMEM_AW-1:0] imem_addr_t;

  // Program counter sequencing
  localparam logic [31:0] PC_STEP  = 32'd4;
  localparam logic [31:0] RESET_PC = 32'd0;

endpackage

`default_nettype wire

/* hdl/fetch_slot_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One fetched instruction on its way to the decode register.
// No ready: a valid slot is taken every cycle unless flushed.
interface fetch_slot_if;

  logic              valid;
  rv_isa_pkg::xlen_t pc;
  rv_isa_pkg::xlen_t insn;

  modport producer (
    output valid, pc, insn
  );

  modport consumer (
    input valid, pc, insn
  );

endinterface

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_imem_we,
  input  core_cfg_pkg::imem_addr_t i_imem_addr,
  input  rv_isa_pkg::xlen_t        i_imem_wdata,
  input  logic                     i_start,
  input  logic                     i_redirect,
  input  rv_isa_pkg::xlen_t        i_target,
  input  logic                     i_ecall,
  output logic                     o_halted,
  fetch_slot_if.producer           slot
);

  rv_isa_pkg::xlen_t        imem [core_cfg_pkg::IMEM_WORDS];
  rv_isa_pkg::xlen_t        pc_q;
  logic                     halted_q;
  core_cfg_pkg::imem_addr_t rd_idx;

  // --------------------------------------------------
  // Instruction memory, loaded from outside
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_wdata;
    end
  end

  assign rd_idx = pc_q[core_cfg_pkg::IMEM_AW+1:2];

  // --------------------------------------------------
  // PC and run control
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q     <= core_cfg_pkg::RESET_PC;
      halted_q <= 1'b1;
    end else if (halted_q) begin
      // Start only counts while idle
      if (i_start) begin
        pc_q     <= core_cfg_pkg::RESET_PC;
        halted_q <= 1'b0;
      end
    end else if (i_ecall) begin
      halted_q <= 1'b1;
    end else if (i_redirect) begin
      pc_q <= i_target;
    end else begin
      pc_q <= pc_q + core_cfg_pkg::PC_STEP;
    end
  end

  // Empty slot carries a nop word
  assign slot.valid = ~halted_q;
  assign slot.pc    = pc_q;
  assign slot.insn  = halted_q ? rv_isa_pkg::INSN_NOP : imem[rd_idx];

  assign o_halted = halted_q;

endmodule

`default_nettype wire

/* hdl/decode_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_buffer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_flush,
  fetch_slot_if.consumer            slot,
  output logic                      o_valid,
  output rv_isa_pkg::decoded_insn_t o_insn
);

  rv_isa_pkg::xlen_t         word;
  rv_isa_pkg::opcode_t       opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic                      f7_alt;
  logic                      f7_zero;
  logic                      imm_ok;
  logic                      rr_ok;
  rv_isa_pkg::alu_op_t       alu_sel;
  rv_isa_pkg::decoded_insn_t dec;

  assign word    = slot.insn;
  assign opcode  = rv_isa_pkg::opcode_t'(word[6:0]);
  assign funct3  = word[14:12];
  assign funct7  = word[31:25];
  assign f7_alt  = (funct7 == rv_isa_pkg::FUNCT7_ALT);
  assign f7_zero = (funct7 == 7'd0);

  // Shift-immediates constrain funct7, the rest do not
  assign imm_ok = (funct3 == 3'b001) ? f7_zero :
                  (funct3 == 3'b101) ? (f7_zero | f7_alt) : 1'b1;
  // Only add/sub and srl/sra have an alternate form
  assign rr_ok  = f7_zero | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101)));

  // --------------------------------------------------
  // funct3/funct7 to ALU operation
  // --------------------------------------------------
  always_comb begin
    case (funct3)
      3'b000:  alu_sel = (opcode == rv_isa_pkg::OP_REG_REG && f7_alt) ?
                         rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      3'b001:  alu_sel = rv_isa_pkg::ALU_SLL;
      3'b010:  alu_sel = rv_isa_pkg::ALU_SLT;
      3'b011:  alu_sel = rv_isa_pkg::ALU_SLTU;
      3'b100:  alu_sel = rv_isa_pkg::ALU_XOR;
      3'b101:  alu_sel = f7_alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  alu_sel = rv_isa_pkg::ALU_OR;
      default: alu_sel = rv_isa_pkg::ALU_AND;
    endcase
  end

  // --------------------------------------------------
  // Field split and immediate build
  // --------------------------------------------------
  always_comb begin
    dec         = '0;
    dec.alu_op  = rv_isa_pkg::ALU_ADD;
    dec.pc      = slot.pc;
    dec.rd      = word[11:7];
    dec.rs1     = word[19:15];
    dec.rs2     = word[24:20];
    dec.br_cond = rv_isa_pkg::br_cond_t'(funct3);
    // Anything not matched below stays a no-op
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        dec.imm     = {word[31:12], 12'b0};
        dec.alu_op  = rv_isa_pkg::ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.we      = 1'b1;
      end
      rv_isa_pkg::OP_JAL: begin
        dec.imm    = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        dec.is_jal = 1'b1;
        dec.we     = 1'b1;
      end
      rv_isa_pkg::OP_REG_IMM: begin
        if (imm_ok) begin
          dec.imm     = {{20{word[31]}}, word[31:20]};
          dec.alu_op  = alu_sel;
          dec.use_imm = 1'b1;
          dec.we      = 1'b1;
        end
      end
      rv_isa_pkg::OP_REG_REG: begin
        if (rr_ok) begin
          dec.alu_op = alu_sel;
          dec.we     = 1'b1;
        end
      end
      rv_isa_pkg::OP_LOAD: begin
        // Word access only
        if (funct3 == 3'b010) begin
          dec.imm     = {{20{word[31]}}, word[31:20]};
          dec.use_imm = 1'b1;
          dec.is_load = 1'b1;
          dec.we      = 1'b1;
        end
      end
      rv_isa_pkg::OP_STORE: begin
        if (funct3 == 3'b010) begin
          dec.imm      = {{20{word[31]}}, word[31:25], word[11:7]};
          dec.use_imm  = 1'b1;
          dec.is_store = 1'b1;
        end
      end
      rv_isa_pkg::OP_BRANCH: begin
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          dec.imm       = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
          dec.is_branch = 1'b1;
        end
      end
      rv_isa_pkg::OP_SYSTEM: begin
        dec.is_ecall = (word[31:7] == 25'd0);
      end
      default: begin
      end
    endcase
  end

  // --------------------------------------------------
  // Pipeline register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else begin
      // Wrong-path word behind a redirect or ecall is dropped
      o_valid <= slot.valid & ~i_flush;
    end
  end

  always_ff @(posedge clk) begin
    if (slot.valid) begin
      o_insn <= dec;
    end
  end

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_valid,
  input  rv_isa_pkg::decoded_insn_t i_insn,
  output logic                      o_redirect,
  output rv_isa_pkg::xlen_t         o_target,
  output logic                      o_ecall,
  output logic                      o_store_valid,
  output rv_isa_pkg::xlen_t         o_store_addr,
  output rv_isa_pkg::xlen_t         o_store_data
);

  rv_isa_pkg::xlen_t                regs [rv_isa_pkg::NUM_REGS];
  rv_isa_pkg::xlen_t                dmem [core_cfg_pkg::DMEM_WORDS];
  rv_isa_pkg::xlen_t                rs1_val;
  rv_isa_pkg::xlen_t                rs2_val;
  rv_isa_pkg::xlen_t                op_b;
  rv_isa_pkg::xlen_t                alu_res;
  rv_isa_pkg::xlen_t                load_data;
  rv_isa_pkg::xlen_t                wb_data;
  logic [core_cfg_pkg::DMEM_AW-1:0] dmem_idx;
  logic                             taken;
  logic                             rf_we;
  logic                             dm_we;

  // --------------------------------------------------
  // Register file read, x0 hardwired to zero
  // --------------------------------------------------
  assign rs1_val = (i_insn.rs1 == '0) ? '0 : regs[i_insn.rs1];
  assign rs2_val = (i_insn.rs2 == '0) ? '0 : regs[i_insn.rs2];

  assign op_b = i_insn.use_imm ? i_insn.imm : rs2_val;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (i_insn.alu_op)
      rv_isa_pkg::ALU_ADD:    alu_res = rs1_val + op_b;
      rv_isa_pkg::ALU_SUB:    alu_res = rs1_val - op_b;
      rv_isa_pkg::ALU_SLL:    alu_res = rs1_val << op_b[4:0];
      rv_isa_pkg::ALU_SLT:    alu_res = {31'd0, $signed(rs1_val) < $signed(op_b)};
      rv_isa_pkg::ALU_SLTU:   alu_res = {31'd0, rs1_val < op_b};
      rv_isa_pkg::ALU_XOR:    alu_res = rs1_val ^ op_b;
      rv_isa_pkg::ALU_SRL:    alu_res = rs1_val >> op_b[4:0];
      rv_isa_pkg::ALU_SRA:    alu_res = $unsigned($signed(rs1_val) >>> op_b[4:0]);
      rv_isa_pkg::ALU_OR:     alu_res = rs1_val | op_b;
      rv_isa_pkg::ALU_AND:    alu_res = rs1_val & op_b;
      rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
      default:                alu_res = '0;
    endcase
  end

  // --------------------------------------------------
  // Branch resolution
  // --------------------------------------------------
  always_comb begin
    case (i_insn.br_cond)
      rv_isa_pkg::BR_EQ:  taken = (rs1_val == rs2_val);
      rv_isa_pkg::BR_NE:  taken = (rs1_val != rs2_val);
      rv_isa_pkg::BR_LT:  taken = ($signed(rs1_val) < $signed(rs2_val));
      rv_isa_pkg::BR_GE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      rv_isa_pkg::BR_LTU: taken = (rs1_val < rs2_val);
      rv_isa_pkg::BR_GEU: taken = (rs1_val >= rs2_val);
      default:            taken = 1'b0;
    endcase
  end

  // Both branch and jal targets are pc relative
  assign o_redirect = i_valid & ((i_insn.is_branch & taken) | i_insn.is_jal);
  assign o_target   = i_insn.pc + i_insn.imm;
  assign o_ecall    = i_valid & i_insn.is_ecall;

  // --------------------------------------------------
  // Data memory, word addressed
  // --------------------------------------------------
  // Low two address bits ignored
  assign dmem_idx  = alu_res[core_cfg_pkg::DMEM_AW+1:2];
  assign load_data = dmem[dmem_idx];
  assign dm_we     = i_valid & i_insn.is_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < core_cfg_pkg::DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (dm_we) begin
      dmem[dmem_idx] <= rs2_val;
    end
  end

  // Store report, same cycle as the write
  assign o_store_valid = dm_we;
  assign o_store_addr  = alu_res;
  assign o_store_data  = rs2_val;

  // --------------------------------------------------
  // Writeback
  // --------------------------------------------------
  always_comb begin
    if (i_insn.is_load) begin
      wb_data = load_data;
    end else if (i_insn.is_jal) begin
      wb_data = i_insn.pc + core_cfg_pkg::PC_STEP;
    end else begin
      wb_data = alu_res;
    end
  end

  // Writes to x0 are dropped here
  assign rf_we = i_valid & i_insn.we & (i_insn.rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we) begin
      regs[i_insn.rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_imem_we,
  input  core_cfg_pkg::imem_addr_t i_imem_addr,
  input  logic [31:0]              i_imem_wdata,
  input  logic                     i_start,
  output logic                     o_halted,
  output logic                     o_store_valid,
  output logic [31:0]              o_store_addr,
  output logic [31:0]              o_store_data
);

  fetch_slot_if slot ();

  logic                      redirect;
  rv_isa_pkg::xlen_t         target;
  logic                      ecall;
  logic                      flush;
  logic                      dec_valid;
  rv_isa_pkg::decoded_insn_t dec_insn;

  // Redirect or ecall kills the word fetched behind it
  assign flush = redirect | ecall;

  fetch_unit u_fetch (
    .clk          (clk),
    .rst          (rst),
    .i_imem_we    (i_imem_we),
    .i_imem_addr  (i_imem_addr),
    .i_imem_wdata (i_imem_wdata),
    .i_start      (i_start),
    .i_redirect   (redirect),
    .i_target     (target),
    .i_ecall      (ecall),
    .o_halted     (o_halted),
    .slot         (slot.producer)
  );

  decode_buffer u_decode (
    .clk     (clk),
    .rst     (rst),
    .i_flush (flush),
    .slot    (slot.consumer),
    .o_valid (dec_valid),
    .o_insn  (dec_insn)
  );

  execute_unit u_exec (
    .clk           (clk),
    .rst           (rst),
    .i_valid       (dec_valid),
    .i_insn        (dec_insn),
    .o_redirect    (redirect),
    .o_target      (target),
    .o_ecall       (ecall),
    .o_store_valid (o_store_valid),
    .o_store_addr  (o_store_addr),
    .o_store_data  (o_store_data)
  );

endmodule

`default_nettype wire

/* bench/rv_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Run control and store reporting rules at the core's top-level ports
module rv_core_checker (
  input logic clk,
  input logic rst,
  input logic i_start,
  input logic i_halted,
  input logic i_store_valid
);

  // A halted core has nothing in flight
  a_no_store_halted: assert property (
    @(posedge clk) disable iff (rst) i_halted |-> !i_store_valid
  ) else $error("store reported while the core is halted");

  // Start while idle begins a run at the next edge
  a_start_runs: assert property (
    @(posedge clk) disable iff (rst) (i_halted && i_start) |=> !i_halted
  ) else $error("core stayed halted after a start pulse");

  // Only a start pulse leaves the halted state
  a_no_spurious_run: assert property (
    @(posedge clk) disable iff (rst) $fell(i_halted) |-> $past(i_start)
  ) else $error("halted dropped without a start pulse");

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     imem_we;
  core_cfg_pkg::imem_addr_t imem_addr;
  logic [31:0]              imem_wdata;
  logic                     start;
  logic                     halted;
  logic                     store_valid;
  logic [31:0]              store_addr;
  logic [31:0]              store_data;

  logic [31:0] rng_state = 32'hfce78a4b;
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] got_addr [$];
  logic [31:0] got_data [$];
  int          run_cycles;

  always #10 clk = ~clk;

  rv_core dut0 (
    .clk           (clk),
    .rst           (rst),
    .i_imem_we     (imem_we),
    .i_imem_addr   (imem_addr),
    .i_imem_wdata  (imem_wdata),
    .i_start       (start),
    .o_halted      (halted),
    .o_store_valid (store_valid),
    .o_store_addr  (store_addr),
    .o_store_data  (store_data)
  );

  bind rv_core rv_core_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .i_start       (i_start),
    .i_halted      (o_halted),
    .i_store_valid (o_store_valid)
  );

  // --------------------------------------------------
  // Instruction encoders and reference model
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // Register-immediate and load forms
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_ecall();
    return 32'h0000_0073;
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: begin
        if (alt) return a - b;
        return a + b;
      end
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        // Arithmetic shift for the alternate form
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // --------------------------------------------------
  // Program building, run control and checks
  // --------------------------------------------------
  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: time %0t signal %s got 0x%08h expected 0x%08h",
               $time, name, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // lui plus addi with the upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(enc_u(upper[31:12], rd));
    emit(enc_i(value[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  task automatic start_run();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= core_cfg_pkg::imem_addr_t'(i);
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    start_run();
  endtask

  // Stores and run length are sampled mid-cycle on the falling edge
  task automatic collect_stores();
    got_addr.delete();
    got_data.delete();
    run_cycles = 0;
    do begin
      @(negedge clk);
      if (store_valid) begin
        got_addr.push_back(store_addr);
        got_data.push_back(store_data);
      end
      if (!halted) begin
        run_cycles = run_cycles + 1;
      end
    end while (!halted);
  endtask

  task automatic compare_stores();
    check("store count", got_addr.size(), exp_addr.size());
    foreach (exp_addr[i]) begin
      check("o_store_addr", got_addr[i], exp_addr[i]);
      check("o_store_data", got_data[i], exp_data[i]);
    end
  endtask

  task automatic run_program();
    load_program();
    collect_stores();
    compare_stores();
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd;
    logic [11:0] imm;
    logic [11:0] off;
    logic [2:0]  f3;
    logic        alt;
    new_program();
    a = lcg_next();
    b = lcg_next();
    load_const(5'd1, a);
    load_const(5'd2, b);
    off = 12'd0;
    // add through and followed by sub and sra
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      emit(enc_r(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, 5'd3));
      emit(enc_s(off, 5'd3, 5'd0));
      expect_store({20'd0, off}, ref_alu(f3, alt, a, b));
      off = off + 12'd4;
    end
    // Immediate forms with srai last
    for (int k = 0; k < 9; k++) begin
      f3  = (k < 8) ? k[2:0] : 3'd5;
      alt = (k == 8);
      rnd = lcg_next();
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {alt ? 7'b0100000 : 7'b0000000, rnd[4:0]};
      end else begin
        imm = rnd[11:0];
      end
      emit(enc_i(imm, 5'd1, f3, 5'd4, 7'b0010011));
      emit(enc_s(off, 5'd4, 5'd0));
      expect_store({20'd0, off}, ref_alu(f3, alt, a, {{20{imm[11]}}, imm}));
      off = off + 12'd4;
    end
    emit(enc_ecall());
    run_program();
  endtask

  task automatic test_x0_load_store();
    logic [31:0] v;
    new_program();
    v = lcg_next();
    emit(enc_i(12'h055, 5'd0, 3'b000, 5'd0, 7'b0010011));
    emit(enc_s(12'h100, 5'd0, 5'd0));
    expect_store(32'h100, 32'd0);
    load_const(5'd5, v);
    emit(enc_s(12'h104, 5'd5, 5'd0));
    expect_store(32'h104, v);
    emit(enc_i(12'h104, 5'd0, 3'b010, 5'd6, 7'b0000011));
    emit(enc_s(12'h108, 5'd6, 5'd0));
    expect_store(32'h108, v);
    emit(enc_ecall());
    run_program();
  endtask

  task automatic test_branches();
    logic [31:0] op_a [4];
    logic [31:0] op_b [4];
    logic [2:0]  conds [6];
    logic [11:0] k;
    new_program();
    // Pairs are equal, both small, negative against positive and reversed
    op_a  = '{32'd5, 32'd3, 32'hffff_fff0, 32'd7};
    op_b  = '{32'd5, 32'd7, 32'd5, 32'd3};
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    k = 12'd0;
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 4; p++) begin
        load_const(5'd1, op_a[p]);
        load_const(5'd2, op_b[p]);
        emit(enc_i(k, 5'd0, 3'b000, 5'd3, 7'b0010011));
        emit(enc_b(13'd8, 5'd2, 5'd1, conds[c]));
        emit(enc_s(12'h200 + (k << 2), 5'd3, 5'd0));
        if (!ref_branch(conds[c], op_a[p], op_b[p])) begin
          expect_store({20'd0, 12'h200 + (k << 2)}, {20'd0, k});
        end
        k = k + 12'd1;
      end
    end
    emit(enc_ecall());
    run_program();
  endtask

  task automatic test_jal();
    logic [31:0] link;
    new_program();
    emit(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b0010011));
    emit(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b0010011));
    link = prog.size() * 4 + 4;
    emit(enc_j(21'd8, 5'd1));
    emit(enc_s(12'h300, 5'd1, 5'd0));
    emit(enc_s(12'h304, 5'd1, 5'd0));
    expect_store(32'h304, link);
    emit(enc_ecall());
    run_program();
  endtask

  task automatic test_halt_illegal();
    logic [31:0] v;
    int          ecall_at;
    new_program();
    v = lcg_next();
    load_const(5'd7, v);
    // Undefined opcode, mul and lb all leave x7 alone
    emit(32'hffff_ffff);
    emit(enc_r(7'b0000001, 5'd7, 5'd7, 3'b000, 5'd7));
    emit(enc_i(12'h000, 5'd0, 3'b000, 5'd7, 7'b0000011));
    emit(enc_s(12'h400, 5'd7, 5'd0));
    expect_store(32'h400, v);
    ecall_at = prog.size();
    emit(enc_ecall());
    emit(enc_s(12'h404, 5'd7, 5'd0));
    run_program();
    // Word N executes in run cycle N+2 and an ecall halts at the end of it
    check("o_halted rise cycle", run_cycles, ecall_at + 2);
    // Rerun from address 0 without reloading
    start_run();
    collect_stores();
    compare_stores();
    check("o_halted rise cycle", run_cycles, ecall_at + 2);
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_alu();
    test_x0_load_store();
    test_branches();
    test_jal();
    test_halt_illegal();
    $display(">>> PASS");
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/rv_isa_pkg.sv
hdl/core_cfg_pkg.sv
hdl/fetch_slot_if.sv
hdl/fetch_unit.sv
hdl/decode_buffer.sv
hdl/execute_unit.sv
hdl/rv_core.sv
bench/rv_core_checker.sv
bench/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module rv_core_tb -o vsim

obj_dir/vsim 2>&1 | tee sim.log

if grep -qxF '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
